/* xgmii_pkg.sv */
package xgmii_pkg;

    // Lanes per 64-bit XGMII word
    localparam int BYTES_PER_WORD = 8;

    // Control characters
    // These only count in a lane whose rxc bit is set
    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hfb;
    localparam logic [7:0] XGMII_TERM  = 8'hfd;

    // Ethernet FCS is the reflected CRC-32
    // State starts at all ones and is inverted at the end
    localparam logic [31:0] CRC_INIT   = 32'hffff_ffff;
    localparam logic [31:0] CRC_POLY   = 32'hedb8_8320;
    localparam logic [31:0] CRC_XOROUT = 32'hffff_ffff;

    // One receive word from the PHY
    // Byte rxd[0] is lane 0, the first on the wire
    typedef struct packed {
        logic [BYTES_PER_WORD-1:0][7:0] rxd;
        logic [BYTES_PER_WORD-1:0]      rxc;
    } xgmii_word_t;

endpackage

/* mac_pkg.sv */
package mac_pkg;

    // APB register map, byte offsets
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_GOOD_CNT = 8'h04;
    localparam logic [7:0] REG_BAD_CNT  = 8'h08;

    // Receive stream beat
    // tuser flags a good CRC and means something only on tlast
    typedef struct packed {
        logic [7:0][7:0] tdata;
        logic [7:0]      tkeep;
        logic            tlast;
        logic            tuser;
    } axis_beat_t;

    // APB requester side
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer side
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Per-frame event from the MAC to the statistics counters
    typedef struct packed {
        logic frame_done;
        logic crc_ok;
    } rx_stat_t;

endpackage

/* crc32_engine.sv */
`timescale 1ns/1ps

module crc32_engine
    import xgmii_pkg::*;
(
    input  logic                           i_clk,
    input  logic                           i_reset,
    input  logic [BYTES_PER_WORD-1:0][7:0] i_data,
    input  logic [BYTES_PER_WORD-1:0]      i_valid,
    output logic [31:0]                    o_crc
);

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // Shift one byte through the reflected register, LSB first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc ^ {24'd0, data};
        for (int b = 0; b < 8; b++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Fold the enabled lanes in wire order
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (i_valid[i]) begin
                crc_next = crc_byte(crc_next, i_data[i]);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            crc_q <= CRC_INIT;
        end else begin
            crc_q <= crc_next;
        end
    end

    // Result already includes this cycle's word
    assign o_crc = crc_next ^ CRC_XOROUT;

endmodule

/* rx_mac.sv */
`timescale 1ns/1ps

module rx_mac
    import xgmii_pkg::*;
    import mac_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  xgmii_word_t i_xgmii,
    input  logic        i_phy_valid,
    input  logic        i_rx_enable,
    output axis_beat_t  o_beat,
    output logic        o_beat_valid,
    output rx_stat_t    o_stat
);

    typedef enum logic {
        ST_IDLE,
        ST_DATA
    } rx_state_t;

    rx_state_t state_q;
    rx_state_t state_next;

    // Start detection
    logic start_l0;
    logic start_l4;
    logic start_ok;
    logic first_hi_q;

    // Terminate detection
    logic [BYTES_PER_WORD-1:0] term_lane;
    logic [2:0]                term_idx;
    logic                      term_found;
    logic                      in_data;

    // Beat shaping
    logic [BYTES_PER_WORD-1:0]      keep;
    logic [BYTES_PER_WORD-1:0]      beat_mask;
    logic [BYTES_PER_WORD-1:0][7:0] beat_data;

    // Previous valid word, feeds the delayed engine and the split FCS
    logic [BYTES_PER_WORD-1:0][7:0] prev_rxd;
    logic [BYTES_PER_WORD-1:0]      prev_mask;

    // CRC check
    logic                      crc_reset;
    logic [BYTES_PER_WORD-1:0] cur_crc_valid;
    logic [BYTES_PER_WORD-1:0] del_crc_valid;
    logic [31:0]               cur_crc;
    logic [31:0]               del_crc;
    logic [127:0]              two_words;
    logic [31:0]               fcs_rx;
    logic                      crc_ok;

    // Mask with every lane below n set
    function automatic logic [7:0] lanes_below(input logic [3:0] n);
        logic [7:0] m;
        for (int i = 0; i < 8; i++) begin
            m[i] = (4'(i) < n);
        end
        return m;
    endfunction

    assign start_l0 = i_phy_valid && i_xgmii.rxc[0] && (i_xgmii.rxd[0] == XGMII_START);
    assign start_l4 = i_phy_valid && i_xgmii.rxc[4] && (i_xgmii.rxd[4] == XGMII_START);
    assign start_ok = (state_q == ST_IDLE) && i_rx_enable && (start_l0 || start_l4);

    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            term_lane[i] = i_xgmii.rxc[i] && (i_xgmii.rxd[i] == XGMII_TERM);
        end
    end

    // Lowest lane holding a terminate code
    always_comb begin
        term_idx = 3'd0;
        for (int i = BYTES_PER_WORD - 1; i >= 0; i--) begin
            if (term_lane[i]) begin
                term_idx = 3'(i);
            end
        end
    end

    assign in_data    = (state_q == ST_DATA) && i_phy_valid;
    assign term_found = in_data && (|term_lane);

    always_comb begin
        state_next = state_q;
        case (state_q)
            ST_IDLE: if (start_ok) state_next = ST_DATA;
            ST_DATA: if (term_found) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state_q    <= ST_IDLE;
            first_hi_q <= 1'b0;
        end else begin
            state_q <= state_next;
            // Lane 4 start leaves preamble in the low half of the next word
            if (start_ok) begin
                first_hi_q <= !start_l0;
            end else if (in_data) begin
                first_hi_q <= 1'b0;
            end
        end
    end

    always_comb begin
        if (term_found) begin
            keep = lanes_below({1'b0, term_idx});
        end else if (first_hi_q) begin
            keep = 8'hf0;
        end else begin
            keep = 8'hff;
        end
    end

    assign beat_mask = keep & {BYTES_PER_WORD{in_data}};

    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            beat_data[i] = beat_mask[i] ? i_xgmii.rxd[i] : 8'h00;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_phy_valid) begin
            prev_rxd <= i_xgmii.rxd;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            prev_mask <= '0;
        end else if (i_phy_valid) begin
            prev_mask <= cur_crc_valid;
        end
    end

    // Engine masks, FCS bytes excluded on the terminate word
    always_comb begin
        cur_crc_valid = beat_mask;
        del_crc_valid = prev_mask & {BYTES_PER_WORD{in_data}};
        if (term_found) begin
            if (term_idx < 3'd4) begin
                // FCS starts in the previous word
                cur_crc_valid = '0;
                del_crc_valid = prev_mask & lanes_below({1'b0, term_idx} + 4'd4);
            end else begin
                cur_crc_valid = lanes_below({1'b0, term_idx} - 4'd4);
            end
        end
    end

    assign crc_reset = i_reset || (state_q == ST_IDLE);

    crc32_engine u_crc_cur (
        .i_clk   (i_clk),
        .i_reset (crc_reset),
        .i_data  (beat_data),
        .i_valid (cur_crc_valid),
        .o_crc   (cur_crc)
    );

    crc32_engine u_crc_del (
        .i_clk   (i_clk),
        .i_reset (crc_reset),
        .i_data  (prev_rxd),
        .i_valid (del_crc_valid),
        .o_crc   (del_crc)
    );

    // FCS is the four bytes just before the terminate lane
    assign two_words = {i_xgmii.rxd, prev_rxd};
    assign fcs_rx    = two_words[{term_idx, 3'b000} + 7'd32 +: 32];
    assign crc_ok    = (term_idx < 3'd4) ? (del_crc == fcs_rx) : (cur_crc == fcs_rx);

    assign o_beat_valid      = in_data;
    assign o_beat.tdata      = beat_data;
    assign o_beat.tkeep      = beat_mask;
    assign o_beat.tlast      = term_found;
    assign o_beat.tuser      = term_found && crc_ok;
    assign o_stat.frame_done = term_found;
    assign o_stat.crc_ok     = term_found && crc_ok;

    a_last_valid: assert property (@(posedge i_clk) disable iff (i_reset)
        o_beat.tlast |-> o_beat_valid);

    // Last beat keeps an unbroken run from lane 0
    a_last_keep: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_beat_valid && o_beat.tlast) |-> ((o_beat.tkeep & (o_beat.tkeep + 8'd1)) == 8'd0));

    a_done_last: assert property (@(posedge i_clk) disable iff (i_reset)
        o_stat.frame_done == (o_beat_valid && o_beat.tlast));

endmodule

/* mac_rx_regs.sv */
`timescale 1ns/1ps

module mac_rx_regs
    import mac_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_reset,
    input  apb_req_t i_apb,
    output apb_rsp_t o_apb,
    input  rx_stat_t i_stat,
    output logic     o_rx_enable
);

    logic        access;
    logic        wr;
    logic        hit_ctrl;
    logic        hit_good;
    logic        hit_bad;
    logic        hit_any;
    logic        rx_enable_q;
    logic [31:0] good_cnt_q;
    logic [31:0] bad_cnt_q;

    // Clear has priority, count stops at all ones
    function automatic logic [31:0] count_next(
        input logic [31:0] cnt,
        input logic        clr,
        input logic        inc
    );
        logic [31:0] n;
        n = cnt;
        if (clr) begin
            n = '0;
        end else if (inc && (cnt != '1)) begin
            n = cnt + 32'd1;
        end
        return n;
    endfunction

    // Access phase of a transfer
    assign access = i_apb.psel && i_apb.penable;
    assign wr     = access && i_apb.pwrite;

    assign hit_ctrl = (i_apb.paddr == REG_CTRL);
    assign hit_good = (i_apb.paddr == REG_GOOD_CNT);
    assign hit_bad  = (i_apb.paddr == REG_BAD_CNT);
    assign hit_any  = hit_ctrl || hit_good || hit_bad;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rx_enable_q <= 1'b0;
            good_cnt_q  <= '0;
            bad_cnt_q   <= '0;
        end else begin
            if (wr && hit_ctrl) begin
                rx_enable_q <= i_apb.pwdata[0];
            end
            // Any write to a counter clears it
            good_cnt_q <= count_next(good_cnt_q, wr && hit_good,
                                     i_stat.frame_done && i_stat.crc_ok);
            bad_cnt_q  <= count_next(bad_cnt_q, wr && hit_bad,
                                     i_stat.frame_done && !i_stat.crc_ok);
        end
    end

    // Read data during the access cycle, zero otherwise
    always_comb begin
        o_apb.prdata = '0;
        if (access && !i_apb.pwrite) begin
            if (hit_ctrl) begin
                o_apb.prdata = {31'd0, rx_enable_q};
            end else if (hit_good) begin
                o_apb.prdata = good_cnt_q;
            end else if (hit_bad) begin
                o_apb.prdata = bad_cnt_q;
            end
        end
    end

    // No wait states
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = access && !hit_any;

    assign o_rx_enable = rx_enable_q;

    a_penable_psel: assert property (@(posedge i_clk) disable iff (i_reset)
        i_apb.penable |-> i_apb.psel);

endmodule

/* mac_rx_top.sv */
`timescale 1ns/1ps

module mac_rx_top
    import xgmii_pkg::*;
    import mac_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,

    // PHY side
    input  xgmii_word_t i_xgmii,
    input  logic        i_phy_valid,

    // Register bus
    input  apb_req_t    i_apb,
    output apb_rsp_t    o_apb,

    // Frame stream, no back-pressure
    output axis_beat_t  o_beat,
    output logic        o_beat_valid
);

    logic     rx_enable;
    rx_stat_t rx_stat;

    mac_rx_regs u_regs (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .i_stat      (rx_stat),
        .o_rx_enable (rx_enable)
    );

    // Beats leave in the cycle their XGMII word arrives
    rx_mac u_rx_mac (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_xgmii      (i_xgmii),
        .i_phy_valid  (i_phy_valid),
        .i_rx_enable  (rx_enable),
        .o_beat       (o_beat),
        .o_beat_valid (o_beat_valid),
        .o_stat       (rx_stat)
    );

endmodule

/* tb_frame_tasks.svh */
`ifndef TB_FRAME_TASKS_SVH
`define TB_FRAME_TASKS_SVH

typedef logic [7:0] byte_q_t[$];

// Bit-serial LFSR form of the Ethernet CRC-32, data LSB first
function automatic logic [31:0] crc32_ref(input byte_q_t bytes);
    logic [31:0] crc;
    logic        fb;
    crc = CRC_INIT;
    foreach (bytes[i]) begin
        for (int b = 0; b < 8; b++) begin
            fb  = crc[0] ^ bytes[i][b];
            crc = crc >> 1;
            if (fb) begin
                crc = crc ^ CRC_POLY;
            end
        end
    end
    return crc ^ CRC_XOROUT;
endfunction

// Random payload, then its FCS low byte first
function automatic byte_q_t build_frame(input int len, input bit corrupt);
    byte_q_t     f;
    logic [31:0] fcs;
    for (int i = 0; i < len; i++) begin
        f.push_back(8'($urandom));
    end
    fcs = crc32_ref(f);
    if (corrupt) begin
        fcs = fcs ^ (32'd1 << $urandom_range(31, 0));
    end
    for (int i = 0; i < 4; i++) begin
        f.push_back(fcs[8*i +: 8]);
    end
    return f;
endfunction

// Payload length that puts the terminate code in lane t
function automatic int len_for_lane(input int t, input int start_lane);
    int d;
    d = ((t - start_lane - 20) % 8 + 8) % 8;
    return 16 + d + 8 * $urandom_range(10, 0);
endfunction

function automatic xgmii_word_t idle_word();
    return {{8{XGMII_IDLE}}, 8'hff};
endfunction

task automatic send_idle(input int n);
    repeat (n) begin
        @(posedge clk);
        xgmii     <= idle_word();
        phy_valid <= 1'b1;
    end
endtask

// Each lane entry is {frame byte, control, data}
task automatic send_frame(input byte_q_t frame, input int start_lane, input int gap_pct,
                          input bit delivered, input bit fcs_good);
    logic [9:0]  lanes[$];
    xgmii_word_t word;
    axis_beat_t  beat;
    int          nwords;
    for (int i = 0; i < start_lane; i++) begin
        lanes.push_back({2'b01, XGMII_IDLE});
    end
    lanes.push_back({2'b01, XGMII_START});
    for (int i = 0; i < 6; i++) begin
        lanes.push_back({2'b00, 8'h55});
    end
    lanes.push_back({2'b00, 8'hd5});
    foreach (frame[i]) begin
        lanes.push_back({2'b10, frame[i]});
    end
    lanes.push_back({2'b01, XGMII_TERM});
    while (lanes.size() % 8 != 0) begin
        lanes.push_back({2'b01, XGMII_IDLE});
    end
    nwords = lanes.size() / 8;
    for (int w = 0; w < nwords; w++) begin
        for (int l = 0; l < 8; l++) begin
            word.rxd[l]   = lanes[8*w + l][7:0];
            word.rxc[l]   = lanes[8*w + l][8];
            beat.tkeep[l] = lanes[8*w + l][9];
            beat.tdata[l] = beat.tkeep[l] ? word.rxd[l] : 8'h00;
        end
        beat.tlast = (w == nwords - 1);
        beat.tuser = beat.tlast && fcs_good;
        // Start word carries no frame bytes
        if (delivered && w > 0) begin
            exp_q.push_back(beat);
        end
        if (w > 0 && $urandom_range(99, 0) < gap_pct) begin
            repeat ($urandom_range(2, 1)) begin
                @(posedge clk);
                xgmii     <= {$urandom, $urandom, 8'($urandom)};
                phy_valid <= 1'b0;
            end
        end
        @(posedge clk);
        xgmii     <= word;
        phy_valid <= 1'b1;
    end
    send_idle(2);
endtask

`endif

/* tb_mac_rx.sv */
`timescale 1ns/1ps

module tb_mac_rx
    import xgmii_pkg::*;
    import mac_pkg::*;
();

    localparam int CLK_PERIOD       = 40;
    localparam int TOTAL_FRAMES     = 20 + 10 + 32 + 20 + 16;
    localparam int FRAME_CYCLES_MAX = 64;
    localparam int APB_CYCLES       = 20 * 3;
    localparam int MARGIN_CYCLES    = 200;

    logic        clk;
    logic        reset;
    xgmii_word_t xgmii;
    logic        phy_valid;
    apb_req_t    apb;
    apb_rsp_t    apb_rsp;
    axis_beat_t  beat;
    logic        beat_valid;

    axis_beat_t  exp_q[$];
    int          errors;
    int          test_errors_base;
    int          tests_ok;
    int          tests_bad;
    string       test_name;

    `include "tb_frame_tasks.svh"

    mac_rx_top dut0 (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_xgmii      (xgmii),
        .i_phy_valid  (phy_valid),
        .i_apb        (apb),
        .o_apb        (apb_rsp),
        .o_beat       (beat),
        .o_beat_valid (beat_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Worst case frame is 18 words, each possibly preceded by two gap cycles
    initial begin
        #(CLK_PERIOD * (TOTAL_FRAMES * FRAME_CYCLES_MAX + APB_CYCLES + MARGIN_CYCLES));
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAIL");
        $finish;
    end

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb.psel    <= 1'b1;
        apb.penable <= 1'b0;
        apb.pwrite  <= wr;
        apb.paddr   <= addr;
        apb.pwdata  <= wdata;
        @(posedge clk);
        apb.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        check("o_apb.pready", apb_rsp.pready, 1'b1);
        @(posedge clk);
        apb <= '0;
    endtask

    task automatic open_test(input string name);
        test_name        = name;
        test_errors_base = errors;
    endtask

    task automatic close_test();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected beats never came out in '%s'", exp_q.size(), test_name);
            errors++;
            exp_q.delete();
        end
        if (errors == test_errors_base) begin
            tests_ok++;
            $display("%s: ok", test_name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", test_name, errors - test_errors_base);
        end
    endtask

    // Outputs are combinational from the word driven at the last rising edge
    initial begin
        axis_beat_t exp_beat;
        forever begin
            @(negedge clk);
            if (!reset && beat_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Output beat arrived with no beat expected, tdata %h", beat.tdata);
                    errors++;
                end else begin
                    exp_beat = exp_q.pop_front();
                    check("o_beat.tdata", beat.tdata, exp_beat.tdata);
                    check("o_beat.tkeep", beat.tkeep, exp_beat.tkeep);
                    check("o_beat.tlast", beat.tlast, exp_beat.tlast);
                    if (exp_beat.tlast) begin
                        check("o_beat.tuser", beat.tuser, exp_beat.tuser);
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          ngood;
        int          nbad;
        bit          bad;
        int          lane;
        void'($urandom(66));
        errors    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        reset     = 1'b1;
        xgmii     = idle_word();
        phy_valid = 1'b0;
        apb       = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        apb_transfer(1'b1, REG_CTRL, 32'd1, rd, err);

        open_test("start lane 0, good FCS");
        for (int n = 0; n < 20; n++) begin
            send_frame(build_frame($urandom_range(120, 16), 1'b0), 0, 0, 1'b1, 1'b1);
        end
        close_test();

        open_test("start lane 4");
        for (int n = 0; n < 10; n++) begin
            send_frame(build_frame($urandom_range(120, 16), 1'b0), 4, 0, 1'b1, 1'b1);
        end
        close_test();

        open_test("every terminate lane");
        for (int s = 0; s <= 4; s += 4) begin
            for (int t = 0; t < 8; t++) begin
                for (int b = 0; b < 2; b++) begin
                    send_frame(build_frame(len_for_lane(t, s), b != 0), s, 0, 1'b1, b == 0);
                end
            end
        end
        close_test();

        open_test("gaps in PHY valid");
        for (int n = 0; n < 20; n++) begin
            bad  = $urandom_range(1, 0);
            lane = 4 * $urandom_range(1, 0);
            send_frame(build_frame($urandom_range(120, 16), bad), lane, 30, 1'b1, !bad);
        end
        close_test();

        open_test("enable and counters");
        apb_transfer(1'b1, REG_GOOD_CNT, 32'd0, rd, err);
        apb_transfer(1'b1, REG_BAD_CNT, 32'd0, rd, err);
        apb_transfer(1'b1, REG_CTRL, 32'd0, rd, err);
        for (int n = 0; n < 4; n++) begin
            send_frame(build_frame($urandom_range(120, 16), n[0]), 0, 0, 1'b0, !n[0]);
        end
        apb_transfer(1'b0, REG_GOOD_CNT, 32'd0, rd, err);
        check("good_cnt", rd, 0);
        check("pslverr", err, 0);
        apb_transfer(1'b0, REG_BAD_CNT, 32'd0, rd, err);
        check("bad_cnt", rd, 0);
        apb_transfer(1'b0, REG_CTRL, 32'd0, rd, err);
        check("ctrl", rd, 0);
        apb_transfer(1'b1, REG_CTRL, 32'd1, rd, err);
        apb_transfer(1'b0, REG_CTRL, 32'd0, rd, err);
        check("ctrl", rd, 1);
        ngood = 0;
        nbad  = 0;
        for (int n = 0; n < 12; n++) begin
            bad = $urandom_range(1, 0);
            if (bad) begin
                nbad++;
            end else begin
                ngood++;
            end
            lane = 4 * $urandom_range(1, 0);
            send_frame(build_frame($urandom_range(120, 16), bad), lane, 10, 1'b1, !bad);
        end
        apb_transfer(1'b0, REG_GOOD_CNT, 32'd0, rd, err);
        check("good_cnt", rd, ngood);
        apb_transfer(1'b0, REG_BAD_CNT, 32'd0, rd, err);
        check("bad_cnt", rd, nbad);
        // Any written value clears the counter
        apb_transfer(1'b1, REG_GOOD_CNT, 32'h1234, rd, err);
        apb_transfer(1'b0, REG_GOOD_CNT, 32'd0, rd, err);
        check("good_cnt", rd, 0);
        apb_transfer(1'b0, REG_BAD_CNT, 32'd0, rd, err);
        check("bad_cnt", rd, nbad);
        apb_transfer(1'b0, 8'h0c, 32'd0, rd, err);
        check("pslverr", err, 1);
        check("prdata", rd, 0);
        apb_transfer(1'b1, 8'h10, 32'hffff_ffff, rd, err);
        check("pslverr", err, 1);
        close_test();

        $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+.
xgmii_pkg.sv
mac_pkg.sv
crc32_engine.sv
rx_mac.sv
mac_rx_regs.sv
mac_rx_top.sv
tb_mac_rx.sv
